// File: Bender.yml
package:
  name: mic_sequencer

sources:
  - files:
      - hdl/mic_pkg.sv
      - hdl/mic_seq_if.sv
      - hdl/mic_cond_sel.sv
      - hdl/mic_loop_counter.sv
      - hdl/mic_branch_ctl.sv
      - hdl/mic_return_stack.sv
      - hdl/mic_addr_sel.sv
      - hdl/mic_sequencer.sv
  - target: test
    files:
      - tb/mic_sequencer_tb.sv

// File: hdl/mic_addr_sel.sv
`timescale 1ns/1ps
`default_nettype none

module mic_addr_sel (
  input  wire                       sysclk,
  input  wire                       rst_n,
  mic_seq_if.path                   seq,
  output logic [mic_pkg::MA_W-1:0]  ma
);

  logic [mic_pkg::MA_W-1:0] ma_q;
  logic [mic_pkg::MA_W-1:0] ma_next;

  // Wraps at 2^13
  assign seq.inc_addr = ma_q + 1'b1;

  always_comb begin
    case (seq.src)
      mic_pkg::SRC_TARGET: ma_next = seq.target;
      mic_pkg::SRC_STACK:  ma_next = seq.ret_addr;
      default:             ma_next = seq.inc_addr;  // Fall through
    endcase
  end

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      ma_q <= '0;
    end else begin
      ma_q <= ma_next;
    end
  end

  assign ma = ma_q;

endmodule

`default_nettype wire

// File: hdl/mic_branch_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module mic_branch_ctl (
  input  mic_pkg::seq_op_e    op,
  input  wire                 cond_en,
  input  wire                 loop,
  input  wire                 ld_ctl,
  input  mic_pkg::cs_field_u  field,
  input  wire                 cond_pass,
  input  wire                 lc_zero,
  mic_seq_if.ctl              seq
);

  logic go;  // Condition satisfied or not required

  assign go = !cond_en || cond_pass;

  // Target is the jump view, zero extended to a full MA
  assign seq.target = {{(mic_pkg::MA_W - mic_pkg::CS_W){1'b0}}, field.jmp.target};

  always_comb begin
    seq.src  = mic_pkg::SRC_INC;
    seq.push = 1'b0;
    seq.pop  = 1'b0;
    if (ld_ctl) begin
      // Setup word, op ignored and MA just advances
      seq.src = mic_pkg::SRC_INC;
    end else if (loop) begin
      // Condition is not looked at on loop branches
      if (op == mic_pkg::SEQ_JUMP && !lc_zero) begin
        seq.src = mic_pkg::SRC_TARGET;
      end
    end else if (go) begin
      case (op)
        mic_pkg::SEQ_JUMP: seq.src = mic_pkg::SRC_TARGET;
        mic_pkg::SEQ_CALL: begin
          seq.src  = mic_pkg::SRC_TARGET;
          seq.push = 1'b1;  // Return to the word after the call
        end
        mic_pkg::SEQ_RET: begin
          seq.src = mic_pkg::SRC_STACK;
          seq.pop = 1'b1;
        end
        default: seq.src = mic_pkg::SRC_INC;
      endcase
    end
  end

  // Loop branches only make sense as jumps; the counter would
  // otherwise decrement with no branch behind it
  always_comb begin : loop_op_check
    if (loop && !ld_ctl) begin
      a_loop_jump: assert #0 (op == mic_pkg::SEQ_JUMP)
        else $error("loop branch without SEQ_JUMP");
    end
  end

endmodule

`default_nettype wire

// File: hdl/mic_cond_sel.sv
`timescale 1ns/1ps
`default_nettype none

module mic_cond_sel (
  input  wire                        sysclk,
  input  wire                        rst_n,
  input  wire                        ld_ctl,
  input  mic_pkg::cs_field_u         field,
  input  wire [mic_pkg::FLAG_W-1:0]  flags,
  output logic                       cond_pass,
  output logic                       cond
);

  logic [mic_pkg::SEL_W-1:0] cond_sel_q;
  logic                      cond_true_q;

  // Condition register, loaded from the control view
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      cond_sel_q  <= '0;    // Flag 0
      cond_true_q <= 1'b1;  // Branch on true
    end else if (ld_ctl) begin
      cond_sel_q  <= field.ctl.cond_sel;
      cond_true_q <= field.ctl.cond_true;
    end
  end

  // Selected flag matched against polarity
  assign cond_pass = (flags[cond_sel_q] == cond_true_q);

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      cond <= 1'b0;
    end else begin
      cond <= cond_pass;  // Visible one cycle after the microword
    end
  end

  // Microcode must never select a flag that does not exist
  a_sel_in_range: assert property (
    @(posedge sysclk) disable iff (!rst_n)
    ld_ctl |=> (int'(cond_sel_q) < mic_pkg::FLAG_W)
  ) else $error("condition select outside flag range");

endmodule

`default_nettype wire

// File: hdl/mic_loop_counter.sv
`timescale 1ns/1ps
`default_nettype none

module mic_loop_counter (
  input  wire                 sysclk,
  input  wire                 rst_n,
  input  wire                 ld_ctl,
  input  wire                 loop,
  input  mic_pkg::cs_field_u  field,
  output logic                lc_zero
);

  logic [mic_pkg::LC_W-1:0] count_q;

  assign lc_zero = (count_q == '0);

  // Load has priority over the loop decrement
  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (ld_ctl) begin
      count_q <= field.ctl.lc_value;
    end else if (loop && !lc_zero) begin
      count_q <= count_q - 1'b1;  // Same cycle the jump is taken
    end
  end

  // An exhausted loop stays at zero
  a_no_wrap: assert property (
    @(posedge sysclk) disable iff (!rst_n)
    (lc_zero && loop && !ld_ctl) |=> lc_zero
  ) else $error("loop counter wrapped below zero");

endmodule

`default_nettype wire

// File: hdl/mic_pkg.sv
`default_nettype none

package mic_pkg;

  // Microprogram address and microword field widths
  parameter int MA_W   = 13;
  parameter int CS_W   = 12;
  parameter int FLAG_W = 8;

  // Control view sub-fields
  parameter int SEL_W = 3;  // Flag index
  parameter int LC_W  = 8;  // Loop count

  // Sequencing operation carried by every microword
  typedef enum logic [1:0] {
    SEQ_NEXT = 2'b00,
    SEQ_JUMP = 2'b01,
    SEQ_CALL = 2'b10,
    SEQ_RET  = 2'b11
  } seq_op_e;

  // Where the next MA comes from
  typedef enum logic [1:0] {
    SRC_INC    = 2'b00,
    SRC_TARGET = 2'b01,
    SRC_STACK  = 2'b10
  } addr_src_e;

  // Branch address view
  typedef struct packed {
    logic [CS_W-1:0] target;
  } cs_jump_t;

  // Condition and loop setup view, loaded by cs_ld_ctl
  typedef struct packed {
    logic [SEL_W-1:0] cond_sel;
    logic             cond_true;  // 1: branch on flag set
    logic [LC_W-1:0]  lc_value;
  } cs_ctl_t;

  // Same microword bits, decoded either way
  typedef union packed {
    cs_jump_t jmp;
    cs_ctl_t  ctl;
  } cs_field_u;

endpackage

`default_nettype wire

// File: hdl/mic_return_stack.sv
`timescale 1ns/1ps
`default_nettype none

module mic_return_stack #(
  parameter int STACK_DEPTH = 4
) (
  input  wire         sysclk,
  input  wire         rst_n,
  mic_seq_if.stack    seq,
  output logic        deep
);

  localparam int PTR_W = $clog2(STACK_DEPTH);
  localparam int CNT_W = $clog2(STACK_DEPTH + 1);

  logic [mic_pkg::MA_W-1:0] mem [STACK_DEPTH];
  logic [PTR_W-1:0]         wr_ptr_q;  // Next free slot, oldest entry when full
  logic [CNT_W-1:0]         cnt_q;
  logic [PTR_W-1:0]         top_idx;
  logic [PTR_W-1:0]         wr_ptr_inc;
  logic                     empty;

  assign empty = (cnt_q == '0);
  assign deep  = (cnt_q == CNT_W'(STACK_DEPTH));

  // Circular indices, depth need not be a power of two
  assign top_idx    = (wr_ptr_q == '0) ? PTR_W'(STACK_DEPTH - 1) : wr_ptr_q - 1'b1;
  assign wr_ptr_inc = (wr_ptr_q == PTR_W'(STACK_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;

  assign seq.ret_addr = empty ? '0 : mem[top_idx];  // Empty pop gives address 0

  always_ff @(posedge sysclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (seq.push) begin
      wr_ptr_q <= wr_ptr_inc;
      if (!deep) begin
        cnt_q <= cnt_q + 1'b1;  // Full push overwrites the oldest
      end
    end else if (seq.pop && !empty) begin
      wr_ptr_q <= top_idx;
      cnt_q    <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge sysclk) begin
    if (seq.push) begin
      mem[wr_ptr_q] <= seq.inc_addr;
    end
  end

  // Microcode should not return more often than it called
  a_no_empty_pop: assert property (
    @(posedge sysclk) disable iff (!rst_n)
    seq.pop |-> !empty
  ) else $error("return stack popped while empty");

endmodule

`default_nettype wire

// File: hdl/mic_seq_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mic_seq_if;

  mic_pkg::addr_src_e      src;       // Next-address source
  logic                    push;      // Save return address
  logic                    pop;       // Drop top entry
  logic [mic_pkg::MA_W-1:0] target;   // Jump target, zero extended
  logic [mic_pkg::MA_W-1:0] ret_addr; // Top of return stack
  logic [mic_pkg::MA_W-1:0] inc_addr; // MA plus one

  // Branch decision side
  modport ctl (output src, push, pop, target);

  // MA register and next-address mux
  modport path (input src, target, ret_addr, output inc_addr);

  // Return stack
  modport stack (input push, pop, inc_addr, output ret_addr);

endinterface

`default_nettype wire

// File: hdl/mic_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module mic_sequencer #(
  parameter int STACK_DEPTH = 4
) (
  input  wire                        sysclk,
  input  wire                        rst_n,
  input  wire [1:0]                  cs_op,
  input  wire                        cs_cond,
  input  wire                        cs_loop,
  input  wire                        cs_ld_ctl,
  input  wire [mic_pkg::CS_W-1:0]    cs_field,
  input  wire [mic_pkg::FLAG_W-1:0]  flags,
  output logic [mic_pkg::MA_W-1:0]   ma,
  output logic                       cond,
  output logic                       lcz,
  output logic                       deep
);

  mic_pkg::cs_field_u field_u;
  mic_pkg::seq_op_e   op;
  logic               cond_pass;

  assign field_u = mic_pkg::cs_field_u'(cs_field);
  assign op      = mic_pkg::seq_op_e'(cs_op);

  mic_seq_if seq_if ();

  mic_cond_sel cond_sel_inst (
    .sysclk    (sysclk),
    .rst_n     (rst_n),
    .ld_ctl    (cs_ld_ctl),
    .field     (field_u),
    .flags     (flags),
    .cond_pass (cond_pass),
    .cond      (cond)
  );

  mic_loop_counter loop_counter_inst (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .ld_ctl  (cs_ld_ctl),
    .loop    (cs_loop),
    .field   (field_u),
    .lc_zero (lcz)
  );

  mic_branch_ctl branch_ctl_inst (
    .op        (op),
    .cond_en   (cs_cond),
    .loop      (cs_loop),
    .ld_ctl    (cs_ld_ctl),
    .field     (field_u),
    .cond_pass (cond_pass),
    .lc_zero   (lcz),
    .seq       (seq_if.ctl)
  );

  mic_return_stack #(
    .STACK_DEPTH (STACK_DEPTH)
  ) return_stack_inst (
    .sysclk (sysclk),
    .rst_n  (rst_n),
    .seq    (seq_if.stack),
    .deep   (deep)
  );

  mic_addr_sel addr_sel_inst (
    .sysclk (sysclk),
    .rst_n  (rst_n),
    .seq    (seq_if.path),
    .ma     (ma)
  );

endmodule

`default_nettype wire

// File: tb/mic_sequencer_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mic_sequencer_tb;

  localparam int DEPTH      = 4;
  localparam int EDGE_LIMIT = 8;  // Clock level changes allowed per wait

  logic                        sysclk;
  logic                        rst_n;
  logic [1:0]                  cs_op;
  logic                        cs_cond;
  logic                        cs_loop;
  logic                        cs_ld_ctl;
  logic [mic_pkg::CS_W-1:0]    cs_field;
  logic [mic_pkg::FLAG_W-1:0]  flags;
  logic [mic_pkg::MA_W-1:0]    ma;
  logic                        cond;
  logic                        lcz;
  logic                        deep;

  // Reference model of the sequencer state
  logic [mic_pkg::MA_W-1:0]    exp_ma;
  logic [mic_pkg::MA_W-1:0]    exp_stack [$];  // Back is the top entry
  logic [7:0]                  exp_lc;
  logic [2:0]                  exp_sel;
  logic                        exp_true;
  logic                        exp_cond;

  int          errors;
  int          checks;
  string       test_name;
  logic [31:0] rnd_state;

  mic_sequencer #(
    .STACK_DEPTH (DEPTH)
  ) mic_sequencer_inst (
    .sysclk    (sysclk),
    .rst_n     (rst_n),
    .cs_op     (cs_op),
    .cs_cond   (cs_cond),
    .cs_loop   (cs_loop),
    .cs_ld_ctl (cs_ld_ctl),
    .cs_field  (cs_field),
    .flags     (flags),
    .ma        (ma),
    .cond      (cond),
    .lcz       (lcz),
    .deep      (deep)
  );

  initial sysclk = 1'b0;
  always #10 sysclk = ~sysclk;  // 20 ns period

  function automatic logic [31:0] next_random();
    rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
    return rnd_state;
  endfunction

  task automatic wait_clock_level(input logic level, input string what);
    int n;
    n = 0;
    @(sysclk);
    while (sysclk !== level && n < EDGE_LIMIT) begin
      @(sysclk);
      n++;
    end
    if (sysclk !== level) begin
      $display("Timeout: clock did not reach the level needed for %s", what);
      $display("Test failures found");
      $finish;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAIL %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_outputs();
    check_value("ma", exp_ma, ma);
    check_value("cond", exp_cond, cond);
    check_value("lcz", exp_lc == 8'd0, lcz);
    check_value("deep", exp_stack.size() == DEPTH, deep);
  endtask

  // Next MA, stack, counter and condition register per the microword rules
  task automatic apply_model(input logic [1:0] op, input logic cnd, input logic lp,
                             input logic ld, input logic [11:0] field,
                             input logic [7:0] flg);
    logic                     pass;
    logic                     go;
    logic [mic_pkg::MA_W-1:0] inc;
    logic [mic_pkg::MA_W-1:0] tgt;
    pass     = (flg[exp_sel] == exp_true);  // Uses the register before this word
    go       = !cnd || pass;
    inc      = exp_ma + 1'b1;
    tgt      = '0;
    tgt[11:0] = field;
    exp_cond = pass;
    if (ld) begin
      exp_ma   = inc;
      exp_sel  = field[11:9];
      exp_true = field[8];
      exp_lc   = field[7:0];
    end else if (lp) begin
      if (exp_lc != 8'd0) begin
        exp_lc = exp_lc - 8'd1;
        exp_ma = (op == mic_pkg::SEQ_JUMP) ? tgt : inc;
      end else begin
        exp_ma = inc;
      end
    end else if (go && op == mic_pkg::SEQ_JUMP) begin
      exp_ma = tgt;
    end else if (go && op == mic_pkg::SEQ_CALL) begin
      if (exp_stack.size() == DEPTH) begin
        void'(exp_stack.pop_front());  // Oldest entry lost
      end
      exp_stack.push_back(inc);
      exp_ma = tgt;
    end else if (go && op == mic_pkg::SEQ_RET) begin
      if (exp_stack.size() == 0) begin
        exp_ma = '0;
      end else begin
        exp_ma = exp_stack.pop_back();
      end
    end else begin
      exp_ma = inc;
    end
  endtask

  // One microword, driven on the falling edge and checked after the rising one
  task automatic drive_word(input logic [1:0] op, input logic cnd, input logic lp,
                            input logic ld, input logic [11:0] field,
                            input logic [7:0] flg);
    cs_op     = op;
    cs_cond   = cnd;
    cs_loop   = lp;
    cs_ld_ctl = ld;
    cs_field  = field;
    flags     = flg;
    apply_model(op, cnd, lp, ld, field, flg);
    wait_clock_level(1'b1, "rising edge");
    #1;
    check_outputs();
    wait_clock_level(1'b0, "falling edge");  // Ready for the next word
  endtask

  task automatic test_reset_and_next();
    logic [31:0] r;
    int          i;
    test_name = "reset_next";
    check_outputs();
    for (i = 0; i < 8; i++) begin
      r = next_random();
      drive_word(mic_pkg::SEQ_NEXT, 1'b0, 1'b0, 1'b0, r[11:0], r[23:16]);
    end
  endtask

  task automatic test_jumps();
    logic [31:0] r;
    int          i;
    test_name = "jumps";
    for (i = 0; i < 4; i++) begin
      r = next_random();
      drive_word(mic_pkg::SEQ_JUMP, 1'b0, 1'b0, 1'b0, r[11:0], r[23:16]);
    end
    for (i = 0; i < 16; i++) begin
      r = next_random();
      // Random flag and polarity, count stays zero
      drive_word(mic_pkg::SEQ_NEXT, 1'b0, 1'b0, 1'b1, {r[2:0], r[3], 8'd0}, r[15:8]);
      r = next_random();
      drive_word(mic_pkg::SEQ_JUMP, 1'b1, 1'b0, 1'b0, r[11:0], r[23:16]);
    end
  endtask

  task automatic test_calls();
    logic [31:0] r;
    int          i;
    test_name = "calls";
    for (i = 0; i <= DEPTH; i++) begin  // One call more than the stack holds
      r = next_random();
      drive_word(mic_pkg::SEQ_CALL, 1'b0, 1'b0, 1'b0, r[11:0], r[23:16]);
      drive_word(mic_pkg::SEQ_NEXT, 1'b0, 1'b0, 1'b0, r[27:16], r[31:24]);
    end
    for (i = 0; i < DEPTH; i++) begin
      r = next_random();
      drive_word(mic_pkg::SEQ_RET, 1'b0, 1'b0, 1'b0, r[11:0], r[23:16]);
    end
  endtask

  task automatic test_loop();
    logic [7:0]  n;
    logic [11:0] t;
    logic [31:0] r;
    int          taken;
    int          i;
    test_name = "loop";
    n = 8'd5;
    drive_word(mic_pkg::SEQ_NEXT, 1'b0, 1'b0, 1'b1, {3'd0, 1'b1, n}, 8'h00);
    t = ma[11:0] + 12'h800;  // Far from any fall-through address
    taken = 0;
    for (i = 0; i <= n; i++) begin
      r = next_random();
      drive_word(mic_pkg::SEQ_JUMP, 1'b0, 1'b1, 1'b0, t, r[7:0]);
      if (ma == {1'b0, t}) begin
        taken++;
      end
    end
    check_value("taken loop jumps", n, taken);
    check_value("lcz after loop", 1, lcz);
  endtask

  task automatic test_failed_cond();
    logic [31:0]              r;
    logic [7:0]               f;
    logic [mic_pkg::MA_W-1:0] call_at;
    test_name = "cond_fail";
    r = next_random();
    call_at = ma;
    drive_word(mic_pkg::SEQ_CALL, 1'b0, 1'b0, 1'b0, r[11:0], r[23:16]);
    drive_word(mic_pkg::SEQ_NEXT, 1'b0, 1'b0, 1'b1, {3'd5, 1'b1, 8'd0}, r[31:24]);
    r = next_random();
    f = r[7:0] & 8'hdf;  // Flag 5 clear so both branches fail
    drive_word(mic_pkg::SEQ_CALL, 1'b1, 1'b0, 1'b0, r[19:8], f);
    drive_word(mic_pkg::SEQ_RET, 1'b1, 1'b0, 1'b0, r[19:8], f);
    drive_word(mic_pkg::SEQ_RET, 1'b0, 1'b0, 1'b0, 12'h000, f);
    check_value("return address", call_at + 1'b1, ma);
    check_value("deep after return", 0, deep);
  endtask

  initial begin
    int i;
    errors    = 0;
    checks    = 0;
    rnd_state = 32'h8427_41b8;
    test_name = "init";
    rst_n     = 1'b0;
    cs_op     = 2'b00;
    cs_cond   = 1'b0;
    cs_loop   = 1'b0;
    cs_ld_ctl = 1'b0;
    cs_field  = '0;
    flags     = '0;
    exp_ma    = '0;
    exp_lc    = '0;
    exp_sel   = '0;
    exp_true  = 1'b1;
    exp_cond  = 1'b0;
    exp_stack.delete();
    for (i = 0; i < 16; i++) begin
      wait_clock_level(1'b1, "reset cycle");
    end
    wait_clock_level(1'b0, "reset release");
    rst_n = 1'b1;  // First microword follows on this same falling edge
    test_reset_and_next();
    test_jumps();
    test_calls();
    test_loop();
    test_failed_cond();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
hdl/mic_pkg.sv
hdl/mic_seq_if.sv
hdl/mic_cond_sel.sv
hdl/mic_loop_counter.sv
hdl/mic_branch_ctl.sv
hdl/mic_return_stack.sv
hdl/mic_addr_sel.sv
hdl/mic_sequencer.sv
tb/mic_sequencer_tb.sv
